// File: rtl/cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////

  // One access from the console or the MCU, valid for a single cycle
  typedef struct packed {
    logic        valid;
    logic        wr;
    logic [23:0] addr;
    logic [7:0]  wdata;
  } host_req_t;

  // Read return, one strobe per accepted read
  typedef struct packed {
    logic       valid;
    logic [7:0] rdata;
  } host_rsp_t;

  // Decoded target of an access
  typedef enum logic [1:0] {
    REG_ROM,
    REG_SRAM,
    REG_MBOX,
    REG_NONE
  } region_e;

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  // Outputs to the 16-bit external memory
  typedef struct packed {
    logic [22:0] addr;
    logic        oe;
    logic        we;
    logic [15:0] wdata;
    // ben[1] is the high byte
    logic [1:0]  ben;
  } mem_bus_t;

  // Strobes from the sequencer into the byte-lane data path
  typedef struct packed {
    logic snes_wr_latch;
    logic mcu_wr_latch;
    logic snes_rd_latch;
    logic mcu_rd_latch;
    logic mbox_sel;
    // Byte address bit 0
    logic lane_lo;
  } lane_ctl_t;

endpackage

// File: rtl/cart_addr_decode.sv
`timescale 1ns/1ps

module cart_addr_decode #(
  parameter int          MBOX_DEPTH = 16,
  parameter logic [23:0] SRAM_BASE  = 24'h800000
) (
  input  cart_pkg::host_req_t          snes_req,
  input  cart_pkg::host_req_t          mcu_req,
  input  logic                         mcu_own,
  output cart_pkg::region_e            region,
  output logic [23:0]                  mem_addr,
  output logic [$clog2(MBOX_DEPTH)-1:0] mbox_idx,
  output logic                         acc_wr,
  output logic                         acc_snes,
  output logic                         acc_go
);
  import cart_pkg::*;

  localparam int          IDX_W    = $clog2(MBOX_DEPTH);
  localparam logic [15:0] MBOX_OFF = 16'h2000;

  host_req_t req_sel;
  logic      snes_mbox;
  logic      snes_sram;
  logic      mcu_mbox;

  // Masters never strobe together, console wins if they do
  assign req_sel  = snes_req.valid ? snes_req : mcu_req;
  assign mbox_idx = req_sel.addr[IDX_W-1:0];
  assign acc_wr   = req_sel.wr;
  assign acc_snes = snes_req.valid;

  // Console map, mailbox window in the low system banks
  assign snes_mbox = (snes_req.addr[23:16] <= 8'h3f) &&
                     (snes_req.addr[15:IDX_W] == MBOX_OFF[15:IDX_W]);
  assign snes_sram = (snes_req.addr[23:16] >= 8'h70) && (snes_req.addr[23:16] <= 8'h7d);

  // MCU sees the mailbox at the very top of its space
  assign mcu_mbox = &mcu_req.addr[23:IDX_W];

  always_comb begin
    region   = REG_NONE;
    mem_addr = '0;
    acc_go   = 1'b0;
    if (snes_req.valid) begin
      if (mcu_own) begin
        // Reads still answer with zero, writes vanish
        acc_go = !snes_req.wr;
      end else if (snes_mbox) begin
        region   = REG_MBOX;
        mem_addr = {{(24-IDX_W){1'b0}}, mbox_idx};
        acc_go   = 1'b1;
      end else if (snes_sram) begin
        region   = REG_SRAM;
        mem_addr = SRAM_BASE + {8'h00, snes_req.addr[15:0]};
        acc_go   = 1'b1;
      end else begin
        region   = REG_ROM;
        mem_addr = {1'b0, snes_req.addr[22:0]};
        acc_go   = !snes_req.wr;
      end
    end else if (mcu_req.valid && mcu_own) begin
      acc_go = 1'b1;
      if (mcu_mbox) begin
        region   = REG_MBOX;
        mem_addr = {{(24-IDX_W){1'b0}}, mbox_idx};
      end else begin
        region   = (mcu_req.addr >= SRAM_BASE) ? REG_SRAM : REG_ROM;
        mem_addr = mcu_req.addr;
      end
    end
  end

endmodule

// File: rtl/cart_access_seq.sv
`timescale 1ns/1ps

module cart_access_seq (
  input  logic                CLK,
  input  logic                rst_n,
  input  cart_pkg::region_e   region,
  input  logic [23:0]         mem_addr,
  input  logic                acc_wr,
  input  logic                acc_snes,
  input  logic                acc_go,
  output cart_pkg::lane_ctl_t lane,
  output cart_pkg::mem_bus_t  mem_bus_ctl,
  output logic                mbox_we,
  output logic                force_zero,
  output logic                snes_rsp_valid,
  output logic                mcu_rsp_valid
);
  import cart_pkg::*;

  // Phase 0 idle, 1 and 2 bus cycles, 3 response
  logic [1:0]  phase;
  logic        snes_q;
  logic        wr_q;
  region_e     region_q;
  logic [23:0] addr_q;
  logic        start;
  logic        mem_cyc;
  logic        rd_done;

  // New access only from idle
  assign start = acc_go && (phase == 2'd0);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= 2'd0;
      snes_q   <= 1'b0;
      wr_q     <= 1'b0;
      region_q <= REG_NONE;
    end else if (start) begin
      phase    <= 2'd1;
      snes_q   <= acc_snes;
      wr_q     <= acc_wr;
      region_q <= region;
    end else if (phase != 2'd0) begin
      phase <= phase + 2'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      addr_q <= mem_addr;
    end
  end

  ////////////////////////////////////////
  // Memory cycle
  ////////////////////////////////////////

  assign mem_cyc = ((phase == 2'd1) || (phase == 2'd2)) &&
                   ((region_q == REG_ROM) || (region_q == REG_SRAM));

  always_comb begin
    mem_bus_ctl       = '0;
    mem_bus_ctl.addr  = addr_q[23:1];
    mem_bus_ctl.oe    = mem_cyc && !wr_q;
    mem_bus_ctl.we    = mem_cyc && wr_q;
    // Odd byte lives in the low lane
    mem_bus_ctl.ben   = mem_cyc ? (addr_q[0] ? 2'b01 : 2'b10) : 2'b00;
  end

  ////////////////////////////////////////
  // Latch strobes and responses
  ////////////////////////////////////////

  assign rd_done = (phase == 2'd2) && !wr_q;

  always_comb begin
    // Write bytes are only present in the request cycle
    lane.snes_wr_latch = start && acc_wr && acc_snes;
    lane.mcu_wr_latch  = start && acc_wr && !acc_snes;
    lane.snes_rd_latch = rd_done && snes_q;
    lane.mcu_rd_latch  = rd_done && !snes_q;
    lane.mbox_sel      = (region_q == REG_MBOX);
    lane.lane_lo       = addr_q[0];
  end

  assign mbox_we        = (phase == 2'd1) && wr_q && (region_q == REG_MBOX);
  assign force_zero     = (region_q == REG_NONE);
  assign snes_rsp_valid = (phase == 2'd3) && !wr_q && snes_q;
  assign mcu_rsp_valid  = (phase == 2'd3) && !wr_q && !snes_q;

endmodule

// File: rtl/cart_data_path.sv
`timescale 1ns/1ps

module cart_data_path (
  input  logic                CLK,
  input  logic                rst_n,
  input  cart_pkg::lane_ctl_t lane,
  input  logic [7:0]          snes_wdata,
  input  logic [7:0]          mcu_wdata,
  input  logic [15:0]         mem_rdata,
  input  logic [7:0]          mbox_rdata,
  input  logic                force_zero,
  output logic [15:0]         mem_wdata,
  output logic [7:0]          mbox_wdata,
  output logic [7:0]          snes_rdata,
  output logic [7:0]          mcu_rdata
);

  logic [7:0] snes_in;
  logic [7:0] mcu_in;
  logic [7:0] snes_out;
  logic [7:0] mcu_out;
  // Last write came from the MCU
  logic       wr_from_mcu;
  logic [7:0] wr_byte;
  logic [7:0] mem_byte;
  logic [7:0] rd_byte;

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      snes_in     <= 8'h00;
      mcu_in      <= 8'h00;
      wr_from_mcu <= 1'b0;
    end else begin
      if (lane.snes_wr_latch) begin
        snes_in     <= snes_wdata;
        wr_from_mcu <= 1'b0;
      end
      if (lane.mcu_wr_latch) begin
        mcu_in      <= mcu_wdata;
        wr_from_mcu <= 1'b1;
      end
    end
  end

  assign wr_byte = wr_from_mcu ? mcu_in : snes_in;

  // Unused lane stays quiet, ben masks it anyway
  assign mem_wdata  = lane.lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign mbox_wdata = wr_byte;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  assign mem_byte = lane.lane_lo ? mem_rdata[7:0] : mem_rdata[15:8];

  // Zero while the MCU owns the bus, then mailbox over memory
  assign rd_byte = force_zero    ? 8'h00 :
                   lane.mbox_sel ? mbox_rdata : mem_byte;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      snes_out <= 8'h00;
      mcu_out  <= 8'h00;
    end else begin
      if (lane.snes_rd_latch) begin
        snes_out <= rd_byte;
      end
      if (lane.mcu_rd_latch) begin
        mcu_out <= rd_byte;
      end
    end
  end

  assign snes_rdata = snes_out;
  assign mcu_rdata  = mcu_out;

endmodule

// File: rtl/cart_mailbox.sv
`timescale 1ns/1ps

module cart_mailbox #(
  parameter int MBOX_DEPTH = 16
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          we,
  input  logic [$clog2(MBOX_DEPTH)-1:0] idx,
  input  logic [7:0]                    wdata,
  output logic [7:0]                    rdata
);

  localparam int IDX_W = $clog2(MBOX_DEPTH);

  // Shared byte registers, both masters meet here
  logic [7:0] regs [MBOX_DEPTH];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MBOX_DEPTH; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (we) begin
      regs[idx] <= wdata;
    end
  end

  // Index is held by the sequencer for the whole access
  assign rdata = regs[idx[IDX_W-1:0]];

endmodule

// File: rtl/cart_data_top.sv
`timescale 1ns/1ps

module cart_data_top #(
  parameter int          MBOX_DEPTH = 16,
  parameter logic [23:0] SRAM_BASE  = 24'h800000
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  cart_pkg::host_req_t snes_req,
  input  cart_pkg::host_req_t mcu_req,
  input  logic                mcu_own,
  input  logic [15:0]         mem_rdata,
  output cart_pkg::host_rsp_t snes_rsp,
  output cart_pkg::host_rsp_t mcu_rsp,
  output cart_pkg::mem_bus_t  mem_bus
);
  import cart_pkg::*;

  localparam int IDX_W = $clog2(MBOX_DEPTH);

  region_e     region;
  logic [23:0] dec_addr;
  logic        acc_wr;
  logic        acc_snes;
  logic        acc_go;
  lane_ctl_t   lane;
  mem_bus_t    bus_ctl;
  logic        mbox_we;
  logic        force_zero;
  logic        snes_rsp_valid;
  logic        mcu_rsp_valid;
  logic [15:0] mem_wdata;
  logic [7:0]  mbox_wdata;
  logic [7:0]  mbox_rdata;
  logic [7:0]  snes_rdata;
  logic [7:0]  mcu_rdata;
  // Registered byte address of the access in flight
  logic [23:0] acc_addr;

  // Mailbox index travels in the low address bits
  cart_addr_decode #(.MBOX_DEPTH(MBOX_DEPTH), .SRAM_BASE(SRAM_BASE)) u_decode (
    .snes_req, .mcu_req, .mcu_own, .region, .mem_addr(dec_addr),
    .mbox_idx(), .acc_wr, .acc_snes, .acc_go
  );

  cart_access_seq u_seq (
    .CLK, .rst_n, .region, .mem_addr(dec_addr), .acc_wr, .acc_snes, .acc_go,
    .lane, .mem_bus_ctl(bus_ctl), .mbox_we, .force_zero, .snes_rsp_valid, .mcu_rsp_valid
  );

  cart_data_path u_data (
    .CLK, .rst_n, .lane, .snes_wdata(snes_req.wdata), .mcu_wdata(mcu_req.wdata),
    .mem_rdata, .mbox_rdata, .force_zero, .mem_wdata, .mbox_wdata, .snes_rdata, .mcu_rdata
  );

  assign acc_addr = {bus_ctl.addr, lane.lane_lo};

  cart_mailbox #(.MBOX_DEPTH(MBOX_DEPTH)) u_mbox (
    .CLK, .rst_n, .we(mbox_we), .idx(acc_addr[IDX_W-1:0]), .wdata(mbox_wdata),
    .rdata(mbox_rdata)
  );

  assign mem_bus  = '{addr: bus_ctl.addr, oe: bus_ctl.oe, we: bus_ctl.we,
                      wdata: mem_wdata, ben: bus_ctl.ben};
  assign snes_rsp = '{valid: snes_rsp_valid, rdata: snes_rdata};
  assign mcu_rsp  = '{valid: mcu_rsp_valid, rdata: mcu_rdata};

endmodule

// File: tb/cart_data_tb.sv
`timescale 1ns/1ps

module cart_data_tb;
  import cart_pkg::*;

  localparam int          MBOX_DEPTH = 16;
  localparam logic [23:0] SRAM_BASE  = 24'h800000;
  localparam int          N_ROM      = 16;
  localparam int          N_SAVE     = 8;
  localparam int          N_MIX      = 40;
  localparam int          N_REQ      = N_ROM + 3 * N_SAVE + 8 + 16 + 20 + N_MIX;

  typedef struct packed {
    logic       snes;
    logic [7:0] data;
    int         due;
  } rsp_exp_t;

  logic        CLK;
  logic        rst_n;
  host_req_t   snes_req;
  host_req_t   mcu_req;
  logic        mcu_own;
  logic [15:0] mem_rdata;
  host_rsp_t   snes_rsp;
  host_rsp_t   mcu_rsp;
  mem_bus_t    mem_bus;
  logic [15:0] mem [65536];
  logic [15:0] shadow [65536];
  logic [7:0]  mbox_sh [MBOX_DEPTH];
  rsp_exp_t    exp_q [$];
  int          cyc;
  int          n_mismatch;
  int          n_other;

  cart_data_top #(.MBOX_DEPTH(MBOX_DEPTH), .SRAM_BASE(SRAM_BASE)) dut (
    .CLK, .rst_n, .snes_req, .mcu_req, .mcu_own, .mem_rdata, .snes_rsp, .mcu_rsp, .mem_bus
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // External memory model
  ////////////////////////////////////////

  // Only the low 16 word-address bits decode
  always @(posedge CLK) begin
    if (mem_bus.we && mem_bus.ben[1]) begin
      mem[mem_bus.addr[15:0]][15:8] = mem_bus.wdata[15:8];
    end
    if (mem_bus.we && mem_bus.ben[0]) begin
      mem[mem_bus.addr[15:0]][7:0] = mem_bus.wdata[7:0];
    end
  end

  assign mem_rdata = mem_bus.oe ? mem[mem_bus.addr[15:0]] : 16'h0000;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Region and memory byte address; MCU direct space counts as writable REG_SRAM
  function automatic region_e classify(input logic snes, input logic [23:0] addr,
                                       output logic [23:0] ba);
    ba = addr;
    if (!snes) begin
      return (addr[23:4] == 20'hfffff) ? REG_MBOX : REG_SRAM;
    end
    if (addr[23:16] <= 8'h3f && addr[15:4] == 12'h200) begin
      return REG_MBOX;
    end
    if (addr[23:16] >= 8'h70 && addr[23:16] <= 8'h7d) begin
      ba = SRAM_BASE + {8'h00, addr[15:0]};
      return REG_SRAM;
    end
    ba = {1'b0, addr[22:0]};
    return REG_ROM;
  endfunction

  function automatic logic [7:0] expect_read(input logic snes, input logic [23:0] addr,
                                             input logic own);
    logic [23:0] ba;
    region_e     r;
    logic [15:0] w;
    r = classify(snes, addr, ba);
    w = shadow[ba[16:1]];
    if (snes && own) begin
      return 8'h00;
    end
    // Odd byte address sits in the low lane
    return (r == REG_MBOX) ? mbox_sh[ba[3:0]] : (ba[0] ? w[7:0] : w[15:8]);
  endfunction

  task automatic check_rsp(input string name, input host_rsp_t rsp, input logic [7:0] exp);
    if (rsp.rdata !== exp) begin
      $display("mismatch %s.rdata: got %h, expected %h", name, rsp.rdata, exp);
      n_mismatch++;
    end
  endtask

  task automatic check_bus(input mem_bus_t bus, input mem_bus_t exp);
    if ({bus.oe, bus.we, bus.ben} !== {exp.oe, exp.we, exp.ben}) begin
      $display("mismatch mem_bus.{oe,we,ben}: got %h, expected %h",
               {bus.oe, bus.we, bus.ben}, {exp.oe, exp.we, exp.ben});
      n_mismatch++;
    end else if ((exp.oe || exp.we) && bus.addr !== exp.addr) begin
      $display("mismatch mem_bus.addr: got %h, expected %h", bus.addr, exp.addr);
      n_mismatch++;
    end else if (exp.we && (bus.wdata & {{8{exp.ben[1]}}, {8{exp.ben[0]}}}) !== exp.wdata) begin
      $display("mismatch mem_bus.wdata: got %h, expected %h", bus.wdata, exp.wdata);
      n_mismatch++;
    end
  endtask

  // One expectation popped per response strobe
  always @(negedge CLK) begin : compare
    rsp_exp_t e;
    if (snes_rsp.valid || mcu_rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("A read response came back with no read outstanding");
        n_other++;
      end else begin
        e = exp_q.pop_front();
        if (e.due != cyc || (e.snes ? !snes_rsp.valid : !mcu_rsp.valid)) begin
          $display("A read response came in cycle %0d or on the wrong side", cyc);
          n_other++;
        end
        check_rsp(e.snes ? "snes_rsp" : "mcu_rsp", e.snes ? snes_rsp : mcu_rsp, e.data);
      end
    end else if (exp_q.size() != 0 && exp_q[0].due < cyc) begin
      $display("A read got no response 3 cycles after its request");
      void'(exp_q.pop_front());
      n_other++;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One request, then hold off until the 4-cycle spacing is met
  task automatic access(input logic snes, input logic wr, input logic [23:0] addr,
                        input logic [7:0] wdata);
    logic [23:0] ba;
    region_e     r;
    logic        taken;
    mem_bus_t    exp;
    rsp_exp_t    e;
    r     = classify(snes, addr, ba);
    taken = snes ? !mcu_own : mcu_own;
    exp   = '0;
    if (taken && r != REG_MBOX && !(wr && r == REG_ROM)) begin
      exp.addr  = ba[23:1];
      exp.oe    = !wr;
      exp.we    = wr;
      exp.ben   = ba[0] ? 2'b01 : 2'b10;
      exp.wdata = ba[0] ? {8'h00, wdata} : {wdata, 8'h00};
    end
    @(negedge CLK);
    if (snes) begin
      snes_req = '{1'b1, wr, addr, wdata};
    end else begin
      mcu_req = '{1'b1, wr, addr, wdata};
    end
    if (!wr && (snes || mcu_own)) begin
      e.snes = snes;
      e.data = expect_read(snes, addr, mcu_own);
      e.due  = cyc + 3;
      exp_q.push_back(e);
    end
    @(negedge CLK);
    snes_req = '0;
    mcu_req  = '0;
    check_bus(mem_bus, exp);
    @(negedge CLK);
    check_bus(mem_bus, exp);
    if (taken && wr && r == REG_MBOX) begin
      mbox_sh[ba[3:0]] = wdata;
    end else if (taken && wr && r == REG_SRAM && ba[0]) begin
      shadow[ba[16:1]][7:0] = wdata;
    end else if (taken && wr && r == REG_SRAM) begin
      shadow[ba[16:1]][15:8] = wdata;
    end
    @(negedge CLK);
  endtask

  task automatic set_own(input logic own);
    @(negedge CLK);
    mcu_own = own;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [23:0] a [N_SAVE];
    void'($urandom(32'h475a));
    snes_req = '0;
    mcu_req  = '0;
    mcu_own  = 1'b0;
    rst_n    = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      r         = $urandom;
      mem[i]    = r[15:0];
      shadow[i] = r[15:0];
    end
    for (int i = 0; i < MBOX_DEPTH; i++) begin
      mbox_sh[i] = 8'h00;
    end
    repeat (10) @(negedge CLK);
    rst_n = 1'b1;

    // ROM reads on both lanes
    for (int i = 0; i < N_ROM; i++) begin
      r = $urandom;
      access(1'b1, 1'b0, {2'b11, r[21:1], i[0]}, 8'h00);
    end
    // Save RAM writes with read-back from both sides
    for (int i = 0; i < N_SAVE; i++) begin
      r    = $urandom;
      a[i] = {8'h70 + 8'(i), r[15:1], i[0]};
      access(1'b1, 1'b1, a[i], r[23:16]);
    end
    for (int i = 0; i < N_SAVE; i++) begin
      access(1'b1, 1'b0, a[i], 8'h00);
    end
    set_own(1'b1);
    for (int i = 0; i < N_SAVE; i++) begin
      access(1'b0, 1'b0, SRAM_BASE + {8'h00, a[i][15:0]}, 8'h00);
    end
    // ROM writes must leave the preload alone
    set_own(1'b0);
    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      access(1'b1, 1'b1, {2'b11, r[21:0]}, r[31:24]);
      access(1'b1, 1'b0, {2'b11, r[21:0]}, 8'h00);
    end
    // Mailbox crossing between the masters
    set_own(1'b1);
    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      access(1'b0, 1'b1, {20'hfffff, 4'(i)}, r[7:0]);
    end
    set_own(1'b0);
    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      access(1'b1, 1'b0, {2'b00, r[21:16], 12'h200, 4'(i)}, 8'h00);
      access(1'b1, 1'b1, {2'b00, r[21:16], 12'h200, 4'(i + 8)}, r[7:0]);
    end
    set_own(1'b1);
    for (int i = 0; i < 4; i++) begin
      access(1'b0, 1'b0, {20'hfffff, 4'(i + 8)}, 8'h00);
    end
    // Bus ownership in both directions
    for (int i = 0; i < 4; i++) begin
      access(1'b1, 1'b0, a[i], 8'h00);
      access(1'b1, 1'b1, a[i], 8'h5a);
    end
    set_own(1'b0);
    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      access(1'b0, 1'b0, r[23:0], 8'h00);
      access(1'b0, 1'b1, r[23:0], r[31:24]);
      access(1'b1, 1'b0, a[i], 8'h00);
    end
    // Random MCU traffic over the whole space
    set_own(1'b1);
    for (int i = 0; i < N_MIX; i++) begin
      r = $urandom;
      d = $urandom;
      access(1'b0, d[8], r[23:0], d[7:0]);
    end

    @(negedge CLK);
    if (exp_q.size() != 0) begin
      $display("Reads were still waiting for a response at the end of the run");
      n_other++;
    end
    $display("Errors: %0d mismatch, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Six cycles per request leaves room for the ownership switches
  initial begin
    repeat (N_REQ * 6 + 10 + 100) @(posedge CLK);
    $display("Timeout, the test sequence did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: sim.f
rtl/cart_pkg.sv
rtl/cart_addr_decode.sv
rtl/cart_access_seq.sv
rtl/cart_data_path.sv
rtl/cart_mailbox.sv
rtl/cart_data_top.sv
tb/cart_data_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge data-path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module cart_data_tb -o cart_data_sim \
  && ./obj_dir/cart_data_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
